//--- design/csr_pkg.sv
/*
   Shared widths, reset values and encodings of the machine-mode CSR unit.
   Only machine and user privilege exist. COUNTER_W must equal 2 * XLEN.
*/
`default_nettype none

package csr_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    localparam int XLEN = 32;
    localparam int COUNTER_W = 64;
    localparam int ECODE_W = 5;
    localparam int ID_W = 4;
    localparam int RETIRE_W = 2;
    localparam int NUM_COUNTERS = 2;
    localparam int CNT_CYCLE = 0;
    localparam int CNT_INSTRET = 1;

    //////////////////////////////////////////////////////////////////////
    // Reset and constant values
    localparam logic [XLEN-1:0] RESET_MTVEC = 32'h0000_0100;
    localparam logic [XLEN-1:0] CPU_ID = 32'h0000_0000;
    // mxl = 1 (32 bit), I and U extensions
    localparam logic [XLEN-1:0] MISA_VALUE = 32'h4010_0100;
    // MPP holds machine out of reset
    localparam logic [XLEN-1:0] RESET_MSTATUS = 32'h0000_1800;

    // mstatus fields
    localparam int MSTATUS_MIE_BIT = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LSB = 11;
    localparam int MSTATUS_MPRV_BIT = 17;

    // Writable bits: MIE, MPIE, MPP, MPRV
    localparam logic [XLEN-1:0] MSTATUS_MASK = 32'h0002_1888;
    // Writable bits: MSIE, MTIE, MEIE
    localparam logic [XLEN-1:0] MIE_MASK = 32'h0000_0888;

    // Interrupt cause codes, also the bit positions in mip and mie
    localparam logic [ECODE_W-1:0] INT_M_SOFTWARE = 5'd3;
    localparam logic [ECODE_W-1:0] INT_M_TIMER = 5'd7;
    localparam logic [ECODE_W-1:0] INT_M_EXTERNAL = 5'd11;

    // Address bits 11:10 of a read-only register
    localparam logic [1:0] CSR_READ_ONLY = 2'b11;

    //////////////////////////////////////////////////////////////////////
    // Enums
    typedef enum logic [11:0] {
        MSTATUS   = 12'h300,
        MISA      = 12'h301,
        MIE       = 12'h304,
        MTVEC     = 12'h305,
        MSCRATCH  = 12'h340,
        MEPC      = 12'h341,
        MCAUSE    = 12'h342,
        MTVAL     = 12'h343,
        MIP       = 12'h344,
        MCYCLE    = 12'hB00,
        MINSTRET  = 12'hB02,
        MCYCLEH   = 12'hB80,
        MINSTRETH = 12'hB82,
        CYCLE     = 12'hC00,
        INSTRET   = 12'hC02,
        CYCLEH    = 12'hC80,
        INSTRETH  = 12'hC82,
        MHARTID   = 12'hF14
    } csr_addr_t;

    typedef enum logic [1:0] {
        CSR_RW = 2'b01,
        CSR_RS = 2'b10,
        CSR_RC = 2'b11
    } csr_op_t;

    typedef enum logic [1:0] {
        USER_PRIVILEGE    = 2'b00,
        MACHINE_PRIVILEGE = 2'b11
    } privilege_t;

endpackage

`default_nettype wire

//--- design/csr_counter.sv
/*
   64-bit event counter. A write to either half suppresses the increment.
*/
`timescale 1ns/1ps
`default_nettype none

module csr_counter (
    input  logic clk,
    input  logic rst,
    input  logic [csr_pkg::RETIRE_W:0] inc,
    input  logic wr_lo,
    input  logic wr_hi,
    input  logic [csr_pkg::XLEN-1:0] wr_data,
    output logic [csr_pkg::COUNTER_W-1:0] value
);
    import csr_pkg::*;

    always_ff @(posedge clk) begin
        if (rst) begin
            value <= '0;
        end else if (wr_lo) begin
            value[XLEN-1:0] <= wr_data;
        end else if (wr_hi) begin
            value[COUNTER_W-1:XLEN] <= wr_data;
        end else begin
            value <= value + COUNTER_W'(inc);
        end
    end

endmodule

`default_nettype wire

//--- design/csr_cmd_ctrl.sv
/*
   One CSR instruction in flight. req_valid is legal only while ready is high.
   Strobes rise the cycle after commit, for machine writable addresses only.
*/
`timescale 1ns/1ps
`default_nettype none

module csr_cmd_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic req_valid,
    input  logic [csr_pkg::ID_W-1:0] req_id,
    input  csr_pkg::csr_op_t req_op,
    input  csr_pkg::csr_addr_t req_addr,
    input  logic [csr_pkg::XLEN-1:0] req_data,
    input  logic [csr_pkg::ID_W-1:0] oldest_id,
    input  logic ack,
    input  logic [csr_pkg::XLEN-1:0] cur_value,
    input  logic [csr_pkg::RETIRE_W-1:0] retire_count,
    output logic ready,
    output logic done,
    output logic [csr_pkg::ID_W-1:0] done_id,
    output logic commit,
    output csr_pkg::csr_addr_t cmd_addr,
    output logic [csr_pkg::XLEN-1:0] wr_data,
    output logic wr_mstatus,
    output logic wr_mtvec,
    output logic wr_mie,
    output logic wr_mepc,
    output logic wr_mcause,
    output logic wr_mtval,
    output logic wr_mscratch,
    output logic [csr_pkg::NUM_COUNTERS-1:0] count_wr_lo,
    output logic [csr_pkg::NUM_COUNTERS-1:0] count_wr_hi,
    output logic [csr_pkg::NUM_COUNTERS-1:0][csr_pkg::RETIRE_W:0] count_inc
);
    import csr_pkg::*;

    logic busy;
    logic commit_in_progress;
    logic mwrite;
    csr_op_t cmd_op;
    logic [XLEN-1:0] cmd_data;

    assign ready = ~busy;

    // Commit once the instruction is the oldest in flight
    assign commit = busy & ~commit_in_progress & (oldest_id == done_id);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            commit_in_progress <= 1'b0;
            done <= 1'b0;
            mwrite <= 1'b0;
        end else begin
            busy <= (busy & ~ack) | req_valid;
            commit_in_progress <= (commit_in_progress & ~req_valid) | commit;
            done <= (done & ~ack) | commit;
            mwrite <= commit & (cmd_addr[11:10] != CSR_READ_ONLY)
                      & (cmd_addr[9:8] == MACHINE_PRIVILEGE);
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            done_id <= req_id;
            cmd_op <= req_op;
            cmd_addr <= req_addr;
            cmd_data <= req_data;
        end
    end

    // Update arithmetic on the value read at commit
    always_ff @(posedge clk) begin
        if (commit) begin
            case (cmd_op)
                CSR_RS: wr_data <= cur_value | cmd_data;
                CSR_RC: wr_data <= cur_value & ~cmd_data;
                default: wr_data <= cmd_data;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Write strobes
    assign wr_mstatus = mwrite & (cmd_addr == MSTATUS);
    assign wr_mtvec = mwrite & (cmd_addr == MTVEC);
    assign wr_mie = mwrite & (cmd_addr == MIE);
    assign wr_mepc = mwrite & (cmd_addr == MEPC);
    assign wr_mcause = mwrite & (cmd_addr == MCAUSE);
    assign wr_mtval = mwrite & (cmd_addr == MTVAL);
    assign wr_mscratch = mwrite & (cmd_addr == MSCRATCH);

    assign count_wr_lo[CNT_CYCLE] = mwrite & (cmd_addr == MCYCLE);
    assign count_wr_hi[CNT_CYCLE] = mwrite & (cmd_addr == MCYCLEH);
    assign count_wr_lo[CNT_INSTRET] = mwrite & (cmd_addr == MINSTRET);
    assign count_wr_hi[CNT_INSTRET] = mwrite & (cmd_addr == MINSTRETH);

    // Cycle counts every clock, instret counts retirements
    assign count_inc[CNT_CYCLE] = (RETIRE_W + 1)'(1);
    assign count_inc[CNT_INSTRET] = {1'b0, retire_count};

endmodule

`default_nettype wire

//--- design/csr_trap_regs.sv
/*
   Privilege level and machine trap registers. mip is read-only here.
   interrupt_taken must come at least one cycle after the interrupt is pending.
*/
`timescale 1ns/1ps
`default_nettype none

module csr_trap_regs (
    input  logic clk,
    input  logic rst,
    input  logic [csr_pkg::XLEN-1:0] wr_data,
    input  logic wr_mstatus,
    input  logic wr_mtvec,
    input  logic wr_mie,
    input  logic wr_mepc,
    input  logic wr_mcause,
    input  logic wr_mtval,
    input  logic wr_mscratch,
    input  logic exception_valid,
    input  logic [csr_pkg::ECODE_W-1:0] exception_code,
    input  logic [csr_pkg::XLEN-1:0] exception_pc,
    input  logic [csr_pkg::XLEN-1:0] exception_tval,
    input  logic interrupt_taken,
    input  logic mret,
    input  logic m_interrupt_software,
    input  logic m_interrupt_timer,
    input  logic m_interrupt_external,
    output logic [csr_pkg::XLEN-1:0] mstatus,
    output logic [csr_pkg::XLEN-1:0] mtvec,
    output logic [csr_pkg::XLEN-1:0] mie,
    output logic [csr_pkg::XLEN-1:0] mip,
    output logic [csr_pkg::XLEN-1:0] mepc,
    output logic [csr_pkg::XLEN-1:0] mcause,
    output logic [csr_pkg::XLEN-1:0] mtval,
    output logic [csr_pkg::XLEN-1:0] mscratch,
    output csr_pkg::privilege_t current_privilege,
    output logic interrupt_pending
);
    import csr_pkg::*;

    logic trap;
    logic [XLEN-1:0] mstatus_next;
    logic [XLEN-1:0] pending;
    logic [ECODE_W-1:0] interrupt_cause_r;
    privilege_t mpp_priv;

    assign trap = exception_valid | interrupt_taken;

    // Only machine or user can be returned to
    assign mpp_priv = (mstatus[MSTATUS_MPP_LSB +: 2] == MACHINE_PRIVILEGE) ?
                      MACHINE_PRIVILEGE : USER_PRIVILEGE;

    always_ff @(posedge clk) begin
        if (rst) begin
            current_privilege <= MACHINE_PRIVILEGE;
        end else if (trap) begin
            current_privilege <= MACHINE_PRIVILEGE;
        end else if (mret) begin
            current_privilege <= mpp_priv;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // mstatus
    always_comb begin
        mstatus_next = mstatus;
        if (wr_mstatus) begin
            mstatus_next = (mstatus & ~MSTATUS_MASK) | (wr_data & MSTATUS_MASK);
        end else if (trap) begin
            mstatus_next[MSTATUS_MPIE_BIT] = mstatus[MSTATUS_MIE_BIT];
            mstatus_next[MSTATUS_MIE_BIT] = 1'b0;
            mstatus_next[MSTATUS_MPP_LSB +: 2] = current_privilege;
        end else if (mret) begin
            mstatus_next[MSTATUS_MIE_BIT] = mstatus[MSTATUS_MPIE_BIT];
            mstatus_next[MSTATUS_MPIE_BIT] = 1'b1;
            mstatus_next[MSTATUS_MPP_LSB +: 2] = USER_PRIVILEGE;
            // Leaving machine mode drops MPRV
            if (mpp_priv != MACHINE_PRIVILEGE) begin
                mstatus_next[MSTATUS_MPRV_BIT] = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus <= RESET_MSTATUS;
        end else begin
            mstatus <= mstatus_next;
        end
    end

    // Direct mode only
    always_ff @(posedge clk) begin
        if (rst) begin
            mtvec <= RESET_MTVEC;
        end else if (wr_mtvec) begin
            mtvec <= {wr_data[XLEN-1:2], 2'b00};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Interrupts
    always_ff @(posedge clk) begin
        if (rst) begin
            mie <= '0;
        end else if (wr_mie) begin
            mie <= wr_data & MIE_MASK;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mip <= '0;
        end else begin
            mip <= '0;
            mip[INT_M_SOFTWARE] <= m_interrupt_software;
            mip[INT_M_TIMER] <= m_interrupt_timer;
            mip[INT_M_EXTERNAL] <= m_interrupt_external;
        end
    end

    assign pending = mip & mie;
    assign interrupt_pending = |pending;

    // External first, then timer, then software
    always_ff @(posedge clk) begin
        if (pending[INT_M_EXTERNAL]) begin
            interrupt_cause_r <= INT_M_EXTERNAL;
        end else if (pending[INT_M_TIMER]) begin
            interrupt_cause_r <= INT_M_TIMER;
        end else begin
            interrupt_cause_r <= INT_M_SOFTWARE;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Trap handling registers
    always_ff @(posedge clk) begin
        if (rst) begin
            mepc <= '0;
        end else if (exception_valid) begin
            mepc <= {exception_pc[XLEN-1:2], 2'b00};
        end else if (wr_mepc) begin
            mepc <= {wr_data[XLEN-1:2], 2'b00};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mcause <= '0;
        end else if (interrupt_taken) begin
            mcause <= {1'b1, {(XLEN-ECODE_W-1){1'b0}}, interrupt_cause_r};
        end else if (exception_valid) begin
            mcause <= {1'b0, {(XLEN-ECODE_W-1){1'b0}}, exception_code};
        end else if (wr_mcause) begin
            mcause <= {wr_data[XLEN-1], {(XLEN-ECODE_W-1){1'b0}}, wr_data[ECODE_W-1:0]};
        end
    end

    always_ff @(posedge clk) begin
        if (exception_valid) begin
            mtval <= exception_tval;
        end else if (wr_mtval) begin
            mtval <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_mscratch) begin
            mscratch <= wr_data;
        end
    end

endmodule

`default_nettype wire

//--- design/csr_read_mux.sv
/*
   Read value of the stored address. Unlisted addresses read zero.
*/
`timescale 1ns/1ps
`default_nettype none

module csr_read_mux (
    input  logic clk,
    input  logic commit,
    input  csr_pkg::csr_addr_t cmd_addr,
    input  logic [csr_pkg::XLEN-1:0] mstatus,
    input  logic [csr_pkg::XLEN-1:0] mtvec,
    input  logic [csr_pkg::XLEN-1:0] mie,
    input  logic [csr_pkg::XLEN-1:0] mip,
    input  logic [csr_pkg::XLEN-1:0] mepc,
    input  logic [csr_pkg::XLEN-1:0] mcause,
    input  logic [csr_pkg::XLEN-1:0] mtval,
    input  logic [csr_pkg::XLEN-1:0] mscratch,
    input  logic [csr_pkg::NUM_COUNTERS-1:0][csr_pkg::COUNTER_W-1:0] count_value,
    output logic [csr_pkg::XLEN-1:0] cur_value,
    output logic [csr_pkg::XLEN-1:0] rd_data
);
    import csr_pkg::*;

    always_comb begin
        case (cmd_addr)
            // Constants
            MISA: cur_value = MISA_VALUE;
            MHARTID: cur_value = CPU_ID;
            // Trap setup and handling
            MSTATUS: cur_value = mstatus;
            MTVEC: cur_value = mtvec;
            MIE: cur_value = mie;
            MIP: cur_value = mip;
            MEPC: cur_value = mepc;
            MCAUSE: cur_value = mcause;
            MTVAL: cur_value = mtval;
            MSCRATCH: cur_value = mscratch;
            // Counters and their user aliases
            MCYCLE, CYCLE: cur_value = count_value[CNT_CYCLE][XLEN-1:0];
            MCYCLEH, CYCLEH: cur_value = count_value[CNT_CYCLE][COUNTER_W-1:XLEN];
            MINSTRET, INSTRET: cur_value = count_value[CNT_INSTRET][XLEN-1:0];
            MINSTRETH, INSTRETH: cur_value = count_value[CNT_INSTRET][COUNTER_W-1:XLEN];
            default: cur_value = '0;
        endcase
    end

    // Old value, before the write lands
    always_ff @(posedge clk) begin
        if (commit) begin
            rd_data <= cur_value;
        end
    end

endmodule

`default_nettype wire

//--- design/csr_unit_top.sv
/*
   Machine-mode CSR unit. Handshake is req_valid pulse, ready level,
   done level until the ack pulse. No back-pressure beyond ack.
*/
`timescale 1ns/1ps
`default_nettype none

module csr_unit_top (
    input  logic clk,
    input  logic rst,
    input  logic req_valid,
    input  logic [csr_pkg::ID_W-1:0] req_id,
    input  csr_pkg::csr_op_t req_op,
    input  csr_pkg::csr_addr_t req_addr,
    input  logic [csr_pkg::XLEN-1:0] req_data,
    output logic ready,
    input  logic [csr_pkg::ID_W-1:0] oldest_id,
    output logic done,
    output logic [csr_pkg::ID_W-1:0] done_id,
    output logic [csr_pkg::XLEN-1:0] rd_data,
    input  logic ack,
    input  logic exception_valid,
    input  logic [csr_pkg::ECODE_W-1:0] exception_code,
    input  logic [csr_pkg::XLEN-1:0] exception_pc,
    input  logic [csr_pkg::XLEN-1:0] exception_tval,
    input  logic interrupt_taken,
    input  logic mret,
    input  logic m_interrupt_software,
    input  logic m_interrupt_timer,
    input  logic m_interrupt_external,
    input  logic [csr_pkg::RETIRE_W-1:0] retire_count,
    output csr_pkg::privilege_t current_privilege,
    output logic interrupt_pending,
    output logic [csr_pkg::XLEN-1:0] trap_target_pc,
    output logic [csr_pkg::XLEN-1:0] epc
);
    import csr_pkg::*;

    logic commit;
    csr_addr_t cmd_addr;
    logic [XLEN-1:0] wr_data;
    logic [XLEN-1:0] cur_value;
    logic wr_mstatus;
    logic wr_mtvec;
    logic wr_mie;
    logic wr_mepc;
    logic wr_mcause;
    logic wr_mtval;
    logic wr_mscratch;
    logic [NUM_COUNTERS-1:0] count_wr_lo;
    logic [NUM_COUNTERS-1:0] count_wr_hi;
    logic [NUM_COUNTERS-1:0][RETIRE_W:0] count_inc;
    logic [NUM_COUNTERS-1:0][COUNTER_W-1:0] count_value;
    logic [XLEN-1:0] mstatus;
    logic [XLEN-1:0] mie;
    logic [XLEN-1:0] mip;
    logic [XLEN-1:0] mcause;
    logic [XLEN-1:0] mtval;
    logic [XLEN-1:0] mscratch;

    csr_cmd_ctrl cmd_ctrl_i (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_id(req_id), .req_op(req_op),
        .req_addr(req_addr), .req_data(req_data),
        .oldest_id(oldest_id), .ack(ack), .cur_value(cur_value),
        .retire_count(retire_count),
        .ready(ready), .done(done), .done_id(done_id),
        .commit(commit), .cmd_addr(cmd_addr), .wr_data(wr_data),
        .wr_mstatus(wr_mstatus), .wr_mtvec(wr_mtvec), .wr_mie(wr_mie),
        .wr_mepc(wr_mepc), .wr_mcause(wr_mcause), .wr_mtval(wr_mtval),
        .wr_mscratch(wr_mscratch),
        .count_wr_lo(count_wr_lo), .count_wr_hi(count_wr_hi), .count_inc(count_inc)
    );

    // mtvec and mepc drive the trap target and return PC directly
    csr_trap_regs trap_regs_i (
        .clk(clk), .rst(rst), .wr_data(wr_data),
        .wr_mstatus(wr_mstatus), .wr_mtvec(wr_mtvec), .wr_mie(wr_mie),
        .wr_mepc(wr_mepc), .wr_mcause(wr_mcause), .wr_mtval(wr_mtval),
        .wr_mscratch(wr_mscratch),
        .exception_valid(exception_valid), .exception_code(exception_code),
        .exception_pc(exception_pc), .exception_tval(exception_tval),
        .interrupt_taken(interrupt_taken), .mret(mret),
        .m_interrupt_software(m_interrupt_software),
        .m_interrupt_timer(m_interrupt_timer),
        .m_interrupt_external(m_interrupt_external),
        .mstatus(mstatus), .mtvec(trap_target_pc), .mie(mie), .mip(mip),
        .mepc(epc), .mcause(mcause), .mtval(mtval), .mscratch(mscratch),
        .current_privilege(current_privilege), .interrupt_pending(interrupt_pending)
    );

    genvar i;
    generate
        for (i = 0; i < NUM_COUNTERS; i++) begin : gen_counters
            csr_counter counter_i (
                .clk(clk), .rst(rst),
                .inc(count_inc[i]),
                .wr_lo(count_wr_lo[i]), .wr_hi(count_wr_hi[i]),
                .wr_data(wr_data),
                .value(count_value[i])
            );
        end
    endgenerate

    csr_read_mux read_mux_i (
        .clk(clk), .commit(commit), .cmd_addr(cmd_addr),
        .mstatus(mstatus), .mtvec(trap_target_pc), .mie(mie), .mip(mip),
        .mepc(epc), .mcause(mcause), .mtval(mtval), .mscratch(mscratch),
        .count_value(count_value),
        .cur_value(cur_value), .rd_data(rd_data)
    );

endmodule

`default_nettype wire

//--- verification/csr_unit_tb.sv
/*
   Random testbench of the CSR unit against a register model.
   Traps, mret and interrupt line changes happen only between requests.
   retire_count stays zero while a request is busy.
*/
`timescale 1ns/1ps
`default_nettype none

module csr_unit_tb;
    import csr_pkg::*;

    localparam int N_OPS = 400;
    localparam int TIMEOUT_CYCLES = N_OPS * 40 + 200;
    // MIE, MPIE, MPP and MPRV
    localparam logic [31:0] MSTATUS_WR_BITS = 32'h0002_1888;
    // MSIE, MTIE and MEIE
    localparam logic [31:0] MIE_WR_BITS = 32'h0000_0888;

    logic clk;
    logic rst;
    logic req_valid;
    logic [ID_W-1:0] req_id;
    csr_op_t req_op;
    csr_addr_t req_addr;
    logic [XLEN-1:0] req_data;
    logic ready;
    logic [ID_W-1:0] oldest_id;
    logic done;
    logic [ID_W-1:0] done_id;
    logic [XLEN-1:0] rd_data;
    logic ack;
    logic exception_valid;
    logic [ECODE_W-1:0] exception_code;
    logic [XLEN-1:0] exception_pc;
    logic [XLEN-1:0] exception_tval;
    logic interrupt_taken;
    logic mret;
    logic m_interrupt_software;
    logic m_interrupt_timer;
    logic m_interrupt_external;
    logic [RETIRE_W-1:0] retire_count;
    privilege_t current_privilege;
    logic interrupt_pending;
    logic [XLEN-1:0] trap_target_pc;
    logic [XLEN-1:0] epc;

    // Reference model state
    logic [31:0] m_mstatus;
    logic [31:0] m_mtvec;
    logic [31:0] m_mie;
    logic [31:0] m_mip;
    logic [31:0] m_mepc;
    logic [31:0] m_mcause;
    logic [31:0] m_mtval;
    logic [31:0] m_mscratch;
    logic [63:0] m_instret;
    logic [31:0] m_cycle_hi;
    logic [31:0] cyc_floor;
    logic [31:0] cyc_base;
    logic [1:0] m_priv;

    int seed = 37117;
    int cycle_count = 0;

    csr_unit_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTBENCH FAILED");
            $fatal(1, "timeout");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    function automatic csr_addr_t pick_addr(input int idx);
        case (idx)
            0: return MSTATUS;
            1: return MISA;
            2: return MIE;
            3: return MTVEC;
            4: return MSCRATCH;
            5: return MEPC;
            6: return MCAUSE;
            7: return MTVAL;
            8: return MIP;
            9: return MCYCLE;
            10: return MINSTRET;
            11: return MCYCLEH;
            12: return MINSTRETH;
            13: return CYCLE;
            14: return INSTRET;
            15: return CYCLEH;
            16: return INSTRETH;
            default: return MHARTID;
        endcase
    endfunction

    function automatic logic [31:0] apply_op(input csr_op_t op, input logic [31:0] old,
                                             input logic [31:0] data);
        case (op)
            CSR_RS: return old | data;
            CSR_RC: return old & ~data;
            default: return data;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Register model
    function automatic logic [31:0] model_value(input csr_addr_t a);
        case (a)
            MSTATUS: return m_mstatus;
            MISA: return MISA_VALUE;
            MIE: return m_mie;
            MTVEC: return m_mtvec;
            MSCRATCH: return m_mscratch;
            MEPC: return m_mepc;
            MCAUSE: return m_mcause;
            MTVAL: return m_mtval;
            MIP: return m_mip;
            MCYCLEH, CYCLEH: return m_cycle_hi;
            MINSTRET, INSTRET: return m_instret[31:0];
            MINSTRETH, INSTRETH: return m_instret[63:32];
            MHARTID: return CPU_ID;
            default: return 32'd0;
        endcase
    endfunction

    // Only machine writable registers change, user aliases stay read-only
    function automatic void model_write(input csr_addr_t a, input logic [31:0] wd);
        case (a)
            MSTATUS: m_mstatus = (m_mstatus & ~MSTATUS_WR_BITS) | (wd & MSTATUS_WR_BITS);
            MIE: m_mie = wd & MIE_WR_BITS;
            MTVEC: m_mtvec = wd & 32'hFFFF_FFFC;
            MSCRATCH: m_mscratch = wd;
            MEPC: m_mepc = wd & 32'hFFFF_FFFC;
            MCAUSE: m_mcause = wd & 32'h8000_001F;
            MTVAL: m_mtval = wd;
            MCYCLEH: m_cycle_hi = wd;
            MINSTRET: m_instret[31:0] = wd;
            MINSTRETH: m_instret[63:32] = wd;
            MCYCLE: begin
                cyc_floor = wd;
                cyc_base = wd;
            end
            default: ;
        endcase
    endfunction

    function automatic void take_trap();
        m_mstatus[7] = m_mstatus[3];
        m_mstatus[3] = 1'b0;
        m_mstatus[12:11] = m_priv;
        m_priv = 2'b11;
    endfunction

    function automatic void take_return();
        logic [1:0] mpp;
        mpp = m_mstatus[12:11];
        m_mstatus[3] = m_mstatus[7];
        m_mstatus[7] = 1'b1;
        m_mstatus[12:11] = 2'b00;
        if (mpp == 2'b11) begin
            m_priv = 2'b11;
        end else begin
            m_priv = 2'b00;
            m_mstatus[17] = 1'b0;
        end
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    task automatic idle_cycles(input int n);
        logic [31:0] r;
        for (int k = 0; k < n; k++) begin
            r = next_rand();
            retire_count = r[1:0];
            m_instret = m_instret + 64'(r[1:0]);
            step();
        end
        retire_count = '0;
    endtask

    // Kinds 0 to 3 are exception, mret, line change, interrupt; others idle
    task automatic apply_event(input int kind);
        logic [31:0] r;
        logic [ECODE_W-1:0] cause;
        step();
        r = next_rand();
        case (kind)
            0: begin
                exception_code = r[4:0];
                exception_pc = next_rand();
                exception_tval = next_rand();
                exception_valid = 1'b1;
                step();
                exception_valid = 1'b0;
                take_trap();
                m_mepc = exception_pc & 32'hFFFF_FFFC;
                m_mcause = {27'd0, exception_code};
                m_mtval = exception_tval;
            end
            1: begin
                mret = 1'b1;
                step();
                mret = 1'b0;
                take_return();
            end
            2: begin
                m_interrupt_software = r[5];
                m_interrupt_timer = r[6];
                m_interrupt_external = r[7];
                step();
                m_mip = '0;
                m_mip[3] = r[5];
                m_mip[7] = r[6];
                m_mip[11] = r[7];
            end
            3: begin
                // External first, then timer, then software
                if (m_mip[11] & m_mie[11]) begin
                    cause = 5'd11;
                end else if (m_mip[7] & m_mie[7]) begin
                    cause = 5'd7;
                end else begin
                    cause = 5'd3;
                end
                interrupt_taken = 1'b1;
                step();
                interrupt_taken = 1'b0;
                take_trap();
                m_mcause = {1'b1, 26'd0, cause};
            end
            default: ;
        endcase
        step();
    endtask

    task automatic check_status();
        check("current_privilege", 32'(m_priv), 32'(current_privilege));
        check("trap_target_pc", m_mtvec, trap_target_pc);
        check("epc", m_mepc, epc);
        check("interrupt_pending", 32'(|(m_mip & m_mie)), 32'(interrupt_pending));
    endtask

    // One request, held back by oldest_id for delay cycles
    task automatic run_csr_op(input csr_op_t op, input csr_addr_t addr,
                              input logic [31:0] data, input int delay,
                              output logic [31:0] got);
        logic [31:0] r;
        logic [ID_W-1:0] id;
        r = next_rand();
        id = r[3:0];
        req_valid = 1'b1;
        req_id = id;
        req_op = op;
        req_addr = addr;
        req_data = data;
        oldest_id = (delay > 0) ? id + 4'd1 : id;
        step();
        req_valid = 1'b0;
        check("ready low while busy", 32'd0, 32'(ready));
        // Each check sees the cycle that just ended with oldest_id still different
        for (int k = 0; k < delay; k++) begin
            step();
            check("done low before oldest", 32'd0, 32'(done));
            check("ready low while busy", 32'd0, 32'(ready));
        end
        oldest_id = id;
        while (done !== 1'b1) begin
            check("ready low while busy", 32'd0, 32'(ready));
            step();
        end
        check("ready low until ack", 32'd0, 32'(ready));
        check("done_id", 32'(id), 32'(done_id));
        got = rd_data;
        ack = 1'b1;
        step();
        ack = 1'b0;
        check("ready after ack", 32'd1, 32'(ready));
        check("done after ack", 32'd0, 32'(done));
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    initial begin
        logic [31:0] r;
        logic [31:0] data;
        logic [31:0] old;
        logic [31:0] got;
        csr_op_t op;
        csr_addr_t addr;

        rst = 1'b1;
        req_valid = 1'b0;
        req_id = '0;
        req_op = CSR_RW;
        req_addr = MSTATUS;
        req_data = '0;
        oldest_id = '0;
        ack = 1'b0;
        exception_valid = 1'b0;
        exception_code = '0;
        exception_pc = '0;
        exception_tval = '0;
        interrupt_taken = 1'b0;
        mret = 1'b0;
        m_interrupt_software = 1'b0;
        m_interrupt_timer = 1'b0;
        m_interrupt_external = 1'b0;
        retire_count = '0;

        m_mstatus = RESET_MSTATUS;
        m_mtvec = RESET_MTVEC;
        m_mie = '0;
        m_mip = '0;
        m_mepc = '0;
        m_mcause = '0;
        m_mtval = '0;
        m_mscratch = '0;
        m_instret = '0;
        m_cycle_hi = '0;
        cyc_floor = '0;
        cyc_base = '0;
        m_priv = 2'b11;

        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        check("ready after reset", 32'd1, 32'(ready));
        check("done after reset", 32'd0, 32'(done));
        check_status();

        // mscratch and mtval have no reset value
        data = next_rand();
        run_csr_op(CSR_RW, MSCRATCH, data, 0, got);
        model_write(MSCRATCH, data);
        data = next_rand();
        run_csr_op(CSR_RW, MTVAL, data, 0, got);
        model_write(MTVAL, data);

        for (int n = 0; n < N_OPS; n++) begin
            r = next_rand();
            idle_cycles(int'(r[1:0]));
            apply_event(int'(r[4:2]));
            check_status();

            r = next_rand();
            addr = pick_addr(int'(r[7:0]) % 18);
            case (r[9:8])
                2'd1: op = CSR_RS;
                2'd2: op = CSR_RC;
                default: op = CSR_RW;
            endcase
            data = next_rand();
            // Low cycle half stays far from a carry into the high half
            if (addr == MCYCLE) begin
                op = CSR_RW;
                data = data & 32'h0FFF_FFFF;
            end
            old = model_value(addr);
            run_csr_op(op, addr, data, int'(r[11:10]), got);
            if (addr == MCYCLE || addr == CYCLE) begin
                check("cycle at or above floor", 32'd1, 32'(got >= cyc_floor));
                check("cycle below window", 32'd1,
                      32'(got < cyc_base + 32'(TIMEOUT_CYCLES)));
                cyc_floor = got;
            end else begin
                check($sformatf("read %s", addr.name()), old, got);
            end
            model_write(addr, apply_op(op, old, data));
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
design/csr_pkg.sv
design/csr_counter.sv
design/csr_cmd_ctrl.sv
design/csr_trap_regs.sv
design/csr_read_mux.sv
design/csr_unit_top.sv
verification/csr_unit_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := csr_unit_tb
FILE_LIST  := src.f
BUILD_DIR  := obj_dir
COMMON     := --timing --top-module $(TOP) -f $(FILE_LIST)
LINT_FLAGS := --lint-only
SIM_FLAGS  := --binary -j 0 --Mdir $(BUILD_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(COMMON)

# The simulation exits non-zero when the testbench stops with $$fatal
sim:
	$(VERILATOR) $(SIM_FLAGS) $(COMMON)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
